// ==== dv/bus_unit_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_unit_props (
	input logic             clk,
	input logic             arst_n_i,
	input logic             ack_i,
	input bus_pkg::word_t   addr_i,
	input bus_pkg::sel_t    sel_i,
	input bus_pkg::cp0_wr_t cp0_wr_i,
	input logic             timer_int_i
);

	logic compare_wr;

	assign compare_wr = cp0_wr_i.we && (cp0_wr_i.addr == bus_pkg::CP0_REG_COMPARE);

	// Pending transfer keeps its address
	addr_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		(sel_i != 4'h0 && !ack_i) |=> $stable(addr_i))
		else $error("wishbone address changed while a transfer was pending");

	sel_cleared: assert property (@(posedge clk) disable iff (!arst_n_i)
		(sel_i != 4'h0 && ack_i) |=> (sel_i == 4'h0))
		else $error("wishbone select still set the cycle after ack");

	// Interrupt only drops through a Compare write
	int_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
		(timer_int_i && !compare_wr) |=> timer_int_i)
		else $error("timer interrupt dropped without a Compare write");

endmodule

bind bus_unit_top bus_unit_props props0 (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.ack_i       (wishbone_ack_i),
	.addr_i      (wishbone_addr_o),
	.sel_i       (wishbone_select_o),
	.cp0_wr_i    (cp0_wr_i),
	.timer_int_i (timer_int_o)
);

`default_nettype wire

// ==== dv/tb_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_bus_unit;

	logic               clk;
	logic               arst_n;
	bus_pkg::port_req_t if_req;
	bus_pkg::port_req_t mem_req;
	bus_pkg::word_t     if_rdata;
	bus_pkg::word_t     mem_rdata;
	logic               stall_if;
	logic               stall_mem;
	bus_pkg::word_t     wb_rdata;
	logic               wb_ack;
	bus_pkg::word_t     wb_addr;
	bus_pkg::word_t     wb_wdata;
	logic               wb_we;
	bus_pkg::sel_t      wb_sel;
	bus_pkg::cp0_wr_t   cp0_wr;
	bus_pkg::word_t     count;
	logic               timer_int;

	// Slave memory model state
	bus_pkg::word_t     mem [256];
	bus_pkg::word_t     addr_log [$];
	integer             seed;
	int                 slave_wait;
	logic               slave_busy;

	bus_unit_top UUT (
		.clk               (clk),
		.arst_n_i          (arst_n),
		.if_req_i          (if_req),
		.mem_req_i         (mem_req),
		.if_rdata_o        (if_rdata),
		.mem_rdata_o       (mem_rdata),
		.stall_req_if_o    (stall_if),
		.stall_req_mem_o   (stall_mem),
		.wishbone_data_i   (wb_rdata),
		.wishbone_ack_i    (wb_ack),
		.wishbone_addr_o   (wb_addr),
		.wishbone_data_o   (wb_wdata),
		.wishbone_we_o     (wb_we),
		.wishbone_select_o (wb_sel),
		.cp0_wr_i          (cp0_wr),
		.count_o           (count),
		.timer_int_o       (timer_int)
	);

	always #10 clk = ~clk;

	function automatic bus_pkg::word_t fill_word(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {a, ~a, a ^ 8'h5a, 8'hc3};
	endfunction

	function automatic bus_pkg::word_t merge_bytes(input bus_pkg::word_t old_w,
		input bus_pkg::word_t new_w, input bus_pkg::sel_t sel);
		bus_pkg::word_t w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return w;
	endfunction

	// kseg0 and kseg1 both begin with 2'b10
	function automatic bus_pkg::word_t phys_of(input bus_pkg::word_t va);
		if (va[31:30] == 2'b10) begin
			return {3'b000, va[28:0]};
		end
		return va;
	endfunction

	function automatic bus_pkg::port_req_t make_req(input logic we, input bus_pkg::sel_t sel,
		input bus_pkg::word_t va, input bus_pkg::word_t wdata);
		bus_pkg::port_req_t r;
		r.ce       = 1'b1;
		r.we       = we;
		r.sel      = sel;
		r.addr.raw = va;
		r.wdata    = wdata;
		return r;
	endfunction

	function automatic logic port_stall(input bit on_mem);
		return on_mem ? stall_mem : stall_if;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input bus_pkg::word_t got,
		input bus_pkg::word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_sel(input string name, input bus_pkg::sel_t got,
		input bus_pkg::sel_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	// Acks 0 to 3 cycles after the select turns nonzero
	always @(negedge clk) begin : slave_model
		logic [7:0] idx;
		wb_ack = 1'b0;
		if (arst_n && wb_sel != 4'h0) begin
			if (!slave_busy) begin
				slave_busy = 1'b1;
				slave_wait = $random(seed) & 3;
				addr_log.push_back(wb_addr);
			end
			if (slave_wait == 0) begin
				idx = wb_addr[9:2];
				if (wb_we) begin
					mem[idx] = merge_bytes(mem[idx], wb_wdata, wb_sel);
				end
				wb_rdata   = mem[idx];
				wb_ack     = 1'b1;
				slave_busy = 1'b0;
			end else begin
				slave_wait--;
			end
		end
	end

	// One request on one port, from ce up to the dropped stall
	task automatic single_access(input bit on_mem, input logic we, input bus_pkg::sel_t sel,
		input bus_pkg::word_t va, input bus_pkg::word_t wdata, input bus_pkg::word_t exp_rdata);
		int n;
		@(negedge clk);
		if (on_mem) begin
			mem_req = make_req(we, sel, va, wdata);
		end else begin
			if_req = make_req(we, sel, va, wdata);
		end
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > 20) begin
				abort_run("timeout waiting for the wishbone select to turn nonzero");
			end
			check_bit("stall_req", port_stall(on_mem), 1'b1);
		end while (wb_sel == 4'h0);
		check_word("wishbone_addr_o", wb_addr, phys_of(va));
		check_sel("wishbone_select_o", wb_sel, sel);
		check_bit("wishbone_we_o", wb_we, we);
		if (we) begin
			check_word("wishbone_data_o", wb_wdata, wdata);
		end
		n = 0;
		while (port_stall(on_mem)) begin
			@(negedge clk);
			n++;
			if (n > 20) begin
				abort_run("timeout waiting for the stall request to drop");
			end
		end
		check_sel("wishbone_select_o", wb_sel, 4'h0);
		if (on_mem) begin
			if (!we) begin
				check_word("mem_rdata_o", mem_rdata, exp_rdata);
			end
			mem_req.ce = 1'b0;
		end else begin
			if (!we) begin
				check_word("if_rdata_o", if_rdata, exp_rdata);
			end
			if_req.ce = 1'b0;
		end
	endtask

	task automatic reset_levels();
		check_sel("wishbone_select_o", wb_sel, 4'h0);
		check_bit("wishbone_we_o", wb_we, 1'b0);
		check_bit("timer_int_o", timer_int, 1'b0);
		check_word("count_o", count, 32'h0);
		check_bit("stall_req_if_o", stall_if, 1'b0);
		check_bit("stall_req_mem_o", stall_mem, 1'b0);
	endtask

	task automatic fetch_from_kseg1();
		single_access(1'b0, 1'b0, 4'hf, 32'hbfc0_0040, 32'h0, fill_word(32'h10));
	endtask

	// Nonzero kuseg segment bits must reach the bus untouched
	task automatic write_then_read();
		single_access(1'b1, 1'b1, 4'b0011, 32'h4000_0120, 32'hdead_beef, 32'h0);
		single_access(1'b1, 1'b0, 4'hf, 32'h4000_0120, 32'h0,
			merge_bytes(fill_word(32'h48), 32'hdead_beef, 4'b0011));
	endtask

	task automatic simultaneous_requests();
		int base;
		int n;
		bit got_if;
		bit got_mem;
		base    = addr_log.size();
		got_if  = 1'b0;
		got_mem = 1'b0;
		n       = 0;
		@(negedge clk);
		if_req  = make_req(1'b0, 4'hf, 32'h8000_0200, 32'h0);
		mem_req = make_req(1'b0, 4'hf, 32'h0000_0300, 32'h0);
		while (!(got_if && got_mem)) begin
			@(negedge clk);
			n++;
			if (n > 60) begin
				abort_run("timeout waiting for both ports to be served");
			end
			if (mem_req.ce && !stall_mem) begin
				check_word("mem_rdata_o", mem_rdata, fill_word(32'hc0));
				mem_req.ce = 1'b0;
				got_mem    = 1'b1;
			end
			if (if_req.ce && !stall_if) begin
				check_word("if_rdata_o", if_rdata, fill_word(32'h80));
				if_req.ce = 1'b0;
				got_if    = 1'b1;
			end
		end
		if (addr_log.size() != base + 2) begin
			abort_run("two requests did not lead to exactly two bus transfers");
		end
		check_word("first transfer address", addr_log[base], 32'h0000_0300);
		check_word("second transfer address", addr_log[base + 1], 32'h0000_0200);
	endtask

	task automatic timer_match();
		bus_pkg::word_t n_val;
		int n;
		n_val = 32'h00ab_0000;
		n     = 0;
		@(negedge clk);
		cp0_wr = {1'b1, bus_pkg::CP0_REG_COUNT, n_val};
		@(negedge clk);
		cp0_wr = {1'b1, bus_pkg::CP0_REG_COMPARE, n_val + 32'd20};
		@(negedge clk);
		cp0_wr.we = 1'b0;
		while (!timer_int) begin
			@(negedge clk);
			n++;
			if (n > 60) begin
				abort_run("timeout waiting for the timer interrupt");
			end
		end
		check_word("count_o", count, n_val + 32'd21);
		@(negedge clk);
		check_bit("timer_int_o", timer_int, 1'b1);
		cp0_wr = {1'b1, bus_pkg::CP0_REG_COMPARE, n_val + 32'd500};
		@(negedge clk);
		cp0_wr.we = 1'b0;
		check_bit("timer_int_o", timer_int, 1'b0);
	endtask

	initial begin
		clk        = 1'b0;
		arst_n     = 1'b0;
		if_req     = '0;
		mem_req    = '0;
		cp0_wr     = '0;
		wb_rdata   = '0;
		wb_ack     = 1'b0;
		seed       = 32'h34b9;
		slave_wait = 0;
		slave_busy = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		reset_levels();
		fetch_from_kseg1();
		write_then_read();
		simultaneous_requests();
		timer_match();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

	// Widths
	localparam int DATA_W     = 32;
	localparam int SEL_W      = 4;
	localparam int CP0_ADDR_W = 5;
	localparam int SEG_W      = 3;
	localparam int OFFSET_W   = DATA_W - SEG_W;

	// CP0 register numbers
	localparam logic [CP0_ADDR_W-1:0] CP0_REG_COUNT   = 5'd9;
	localparam logic [CP0_ADDR_W-1:0] CP0_REG_COMPARE = 5'd11;

	// Unmapped segments
	localparam logic [SEG_W-1:0] SEG_KSEG0 = 3'b100;
	localparam logic [SEG_W-1:0] SEG_KSEG1 = 3'b101;

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [SEL_W-1:0]      sel_t;
	typedef logic [CP0_ADDR_W-1:0] cp0_addr_t;

	// Segment view of a virtual address
	typedef struct packed {
		logic [SEG_W-1:0]    seg;
		logic [OFFSET_W-1:0] offset;
	} vaddr_fields_t;

	typedef union packed {
		word_t         raw;
		vaddr_fields_t fields;
	} vaddr_u;

	// Request from a pipeline memory port
	typedef struct packed {
		logic   ce;
		logic   we;
		sel_t   sel;
		vaddr_u addr;
		word_t  wdata;
	} port_req_t;

	// Translated request towards the bus master
	typedef struct packed {
		logic  valid;
		logic  we;
		sel_t  sel;
		word_t addr;
		word_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic      we;
		cp0_addr_t addr;
		word_t     data;
	} cp0_wr_t;

endpackage

`default_nettype wire

// ==== hw/bus_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_unit_top (
	input  logic               clk,
	input  logic               arst_n_i,

	// Pipeline ports
	input  bus_pkg::port_req_t if_req_i,
	input  bus_pkg::port_req_t mem_req_i,
	output bus_pkg::word_t     if_rdata_o,
	output bus_pkg::word_t     mem_rdata_o,
	output logic               stall_req_if_o,
	output logic               stall_req_mem_o,

	// Wishbone side
	input  bus_pkg::word_t     wishbone_data_i,
	input  logic               wishbone_ack_i,
	output bus_pkg::word_t     wishbone_addr_o,
	output bus_pkg::word_t     wishbone_data_o,
	output logic               wishbone_we_o,
	output bus_pkg::sel_t      wishbone_select_o,

	// CP0 timer
	input  bus_pkg::cp0_wr_t   cp0_wr_i,
	output bus_pkg::word_t     count_o,
	output logic               timer_int_o
);

	bus_pkg::bus_req_t bus_req;
	bus_pkg::word_t    bus_rdata;
	logic              accept;
	logic              done;

	port_arbiter port_arbiter0 (
		.clk             (clk),
		.arst_n_i        (arst_n_i),

		.if_req_i        (if_req_i),
		.mem_req_i       (mem_req_i),

		.accept_i        (accept),
		.done_i          (done),
		.rdata_i         (bus_rdata),

		.bus_req_o       (bus_req),
		.if_rdata_o      (if_rdata_o),
		.mem_rdata_o     (mem_rdata_o),
		.stall_req_if_o  (stall_req_if_o),
		.stall_req_mem_o (stall_req_mem_o)
	);

	wb_master_fsm wb_master_fsm0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),

		.bus_req_i   (bus_req),

		.wb_data_i   (wishbone_data_i),
		.wb_ack_i    (wishbone_ack_i),
		.wb_addr_o   (wishbone_addr_o),
		.wb_data_o   (wishbone_data_o),
		.wb_we_o     (wishbone_we_o),
		.wb_select_o (wishbone_select_o),

		.accept_o    (accept),
		.done_o      (done),
		.rdata_o     (bus_rdata)
	);

	// Compare is not brought out at this level
	cp0_timer cp0_timer0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),

		.cp0_wr_i    (cp0_wr_i),

		.count_o     (count_o),
		.compare_o   (),
		.timer_int_o (timer_int_o)
	);

endmodule

`default_nettype wire

// ==== hw/cp0_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_timer (
	input  logic             clk,
	input  logic             arst_n_i,

	input  bus_pkg::cp0_wr_t cp0_wr_i,

	output bus_pkg::word_t   count_o,
	output bus_pkg::word_t   compare_o,
	output logic             timer_int_o
);

	bus_pkg::word_t count_q;
	bus_pkg::word_t compare_q;
	logic           timer_int_q;
	logic           count_wr;
	logic           compare_wr;
	logic           match;

	// Other register numbers fall through
	assign count_wr   = cp0_wr_i.we && (cp0_wr_i.addr == bus_pkg::CP0_REG_COUNT);
	assign compare_wr = cp0_wr_i.we && (cp0_wr_i.addr == bus_pkg::CP0_REG_COMPARE);

	// Compare of zero disables the timer
	assign match = (compare_q != '0) && (count_q == compare_q);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			count_q <= '0;
		end else if (count_wr) begin
			count_q <= cp0_wr_i.data;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			compare_q <= '0;
		end else if (compare_wr) begin
			compare_q <= cp0_wr_i.data;
		end
	end

	// Sticky until software rewrites Compare
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			timer_int_q <= 1'b0;
		end else if (compare_wr) begin
			timer_int_q <= 1'b0;
		end else if (match) begin
			timer_int_q <= 1'b1;
		end
	end

	assign count_o     = count_q;
	assign compare_o   = compare_q;
	assign timer_int_o = timer_int_q;

endmodule

`default_nettype wire

// ==== hw/port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
	input  logic               clk,
	input  logic               arst_n_i,

	input  bus_pkg::port_req_t if_req_i,
	input  bus_pkg::port_req_t mem_req_i,

	input  logic               accept_i,
	input  logic               done_i,
	input  bus_pkg::word_t     rdata_i,

	output bus_pkg::bus_req_t  bus_req_o,
	output bus_pkg::word_t     if_rdata_o,
	output bus_pkg::word_t     mem_rdata_o,
	output logic               stall_req_if_o,
	output logic               stall_req_mem_o
);

	bus_pkg::port_req_t pick;
	bus_pkg::word_t     phys_addr;
	logic               pick_mem;
	logic               unmapped;
	logic               busy_q;
	logic               owner_mem_q;
	logic               if_done;
	logic               mem_done;

	// Data port wins
	assign pick_mem = mem_req_i.ce;
	assign pick     = pick_mem ? mem_req_i : if_req_i;

	// kseg0/kseg1 drop the segment bits, everything else passes as is
	assign unmapped = (pick.addr.fields.seg == bus_pkg::SEG_KSEG0) ||
	                  (pick.addr.fields.seg == bus_pkg::SEG_KSEG1);

	always_comb begin
		if (unmapped) begin
			phys_addr = {{bus_pkg::SEG_W{1'b0}}, pick.addr.fields.offset};
		end else begin
			phys_addr = pick.addr.raw;
		end
	end

	always_comb begin
		bus_req_o.valid = (if_req_i.ce || mem_req_i.ce) && !busy_q;
		bus_req_o.we    = pick.we;
		bus_req_o.sel   = pick.sel;
		bus_req_o.addr  = phys_addr;
		bus_req_o.wdata = pick.wdata;
	end

	// Owner of the transfer in flight
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q      <= 1'b0;
			owner_mem_q <= 1'b0;
		end else if (accept_i) begin
			busy_q      <= 1'b1;
			owner_mem_q <= pick_mem;
		end else if (done_i) begin
			busy_q <= 1'b0;
		end
	end

	assign if_done  = done_i && !owner_mem_q;
	assign mem_done = done_i && owner_mem_q;

	// Read word only shows up in the owner's done cycle
	assign if_rdata_o  = if_done ? rdata_i : '0;
	assign mem_rdata_o = mem_done ? rdata_i : '0;

	assign stall_req_if_o  = if_req_i.ce && !if_done;
	assign stall_req_mem_o = mem_req_i.ce && !mem_done;

endmodule

`default_nettype wire

// ==== hw/wb_master_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_master_fsm (
	input  logic              clk,
	input  logic              arst_n_i,

	input  bus_pkg::bus_req_t bus_req_i,

	input  bus_pkg::word_t    wb_data_i,
	input  logic              wb_ack_i,
	output bus_pkg::word_t    wb_addr_o,
	output bus_pkg::word_t    wb_data_o,
	output logic              wb_we_o,
	output bus_pkg::sel_t     wb_select_o,

	output logic              accept_o,
	output logic              done_o,
	output bus_pkg::word_t    rdata_o
);

	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_BUSY = 2'd1,
		ST_DONE = 2'd2
	} state_e;

	state_e         state_q;
	state_e         state_d;
	bus_pkg::sel_t  req_sel;
	bus_pkg::word_t rdata_q;
	logic           ack_seen;

	assign accept_o = (state_q == ST_IDLE) && bus_req_i.valid;
	assign ack_seen = (state_q == ST_BUSY) && wb_ack_i;
	assign done_o   = (state_q == ST_DONE);

	// A zero select is taken as a full word access
	assign req_sel = (bus_req_i.sel == '0) ? '1 : bus_req_i.sel;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (accept_o) begin
					state_d = ST_BUSY;
				end
			end
			ST_BUSY: begin
				if (wb_ack_i) begin
					state_d = ST_DONE;
				end
			end
			ST_DONE: begin
				state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= ST_IDLE;
			wb_we_o     <= 1'b0;
			wb_select_o <= '0;
		end else begin
			state_q <= state_d;
			if (accept_o) begin
				wb_we_o     <= bus_req_i.we;
				wb_select_o <= req_sel;
			end else if (ack_seen) begin
				// Bus goes quiet on the edge after ack
				wb_we_o     <= 1'b0;
				wb_select_o <= '0;
			end
		end
	end

	// Address and write data
	always_ff @(posedge clk) begin
		if (accept_o) begin
			wb_addr_o <= bus_req_i.addr;
			wb_data_o <= bus_req_i.wdata;
		end
	end

	// Read data sampled with ack
	always_ff @(posedge clk) begin
		if (ack_seen && !wb_we_o) begin
			rdata_q <= wb_data_i;
		end
	end

	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== project.f ====
hw/bus_pkg.sv
hw/port_arbiter.sv
hw/wb_master_fsm.sv
hw/cp0_timer.sv
hw/bus_unit_top.sv
dv/bus_unit_props.sv
dv/tb_bus_unit.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module tb_bus_unit \
		-f project.f -o sim_bus_unit \
	&& ./obj_dir/sim_bus_unit 2>&1 | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
